/* Bender.yml */
package:
  name: conn_context

sources:
  - include_dirs:
      - .
    files:
      - ctx_pkg.sv
      - ctx_lookup_if.sv
      - ctx_req_capture.sv
      - ctx_rr_arbiter.sv
      - ctx_index_table.sv
      - ctx_data_mem.sv
      - conn_context_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - conn_context_sva.sv
      - conn_context_tb.sv

/* all.f */
+incdir+.
ctx_pkg.sv
ctx_lookup_if.sv
ctx_req_capture.sv
ctx_rr_arbiter.sv
ctx_index_table.sv
ctx_data_mem.sv
conn_context_top.sv
conn_context_sva.sv
conn_context_tb.sv

/* conn_context_sva.sv */
// Lookup port assertions
`include "ctx_defs.svh"

module conn_context_sva (
	input logic clk,
	input logic rst_n,
	input logic [`NUM_PU-1:0] io_req,
	input ctx_pkg::pu_addr_u io_addr [`NUM_PU],
	input logic [`NUM_PU-1:0] io_ack,
	input ctx_pkg::ctx_word_t io_ack_data [`NUM_PU],
	input logic cfg_rd,
	input logic cfg_wr,
	input logic cfg_ack
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CFG_LIMIT = 64;

	logic [`NUM_PU-1:0] ctx_req;
	int outstanding; // Accepted requests not yet acked.
	int error_count = 0;

	always_comb begin
		for (int i = 0; i < `NUM_PU; i++)
			ctx_req[i] = io_req[i] && (io_addr[i].rgn.region == `REGION_W'(`CTX_REGION));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			outstanding <= 0;
		else
			outstanding <= outstanding + $countones(ctx_req) - $countones(io_ack);
	end

	a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(io_ack))
	else begin
		$error("io_ack is set for more than one PU");
		error_count++;
	end

	for (genvar i = 0; i < `NUM_PU; i++) begin : g_pu
		a_idle_data_zero: assert property (@(posedge clk) disable iff (!rst_n)
			!io_ack[i] |-> io_ack_data[i] == '0)
		else begin
			$error("io_ack_data of PU %0d is nonzero without an ack", i);
			error_count++;
		end

		// Lone request into an empty pipeline.
		a_single_latency: assert property (@(posedge clk) disable iff (!rst_n)
			(ctx_req == (`NUM_PU'(1) << i)) && (outstanding == 0)
			|-> ##1 (!io_ack[i]) [*3] ##1 io_ack[i])
		else begin
			$error("PU %0d single request not acked after 4 cycles", i);
			error_count++;
		end
	end

	a_cfg_done: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cfg_rd || cfg_wr) |-> ##[1:CFG_LIMIT] cfg_ack)
	else begin
		$error("configuration access got no cfg_ack");
		error_count++;
	end

	a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> (io_ack == '0) && !cfg_ack)
	else begin
		$error("ack outputs not low after reset");
		error_count++;
	end

endmodule

bind conn_context_top conn_context_sva sva_i (
	.clk(clk),
	.rst_n(rst_n),
	.io_req(io_req),
	.io_addr(io_addr),
	.io_ack(io_ack),
	.io_ack_data(io_ack_data),
	.cfg_rd(cfg_rd),
	.cfg_wr(cfg_wr),
	.cfg_ack(cfg_ack)
);

/* conn_context_tb.sv */
// Connection context lookup testbench
`include "ctx_defs.svh"

module conn_context_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ACK_TIMEOUT = 60;
	localparam int CFG_TIMEOUT = 60;

	logic clk;
	logic rst_n;
	logic [`NUM_PU-1:0] io_req;
	ctx_pkg::pu_addr_u io_addr [`NUM_PU];
	logic [`NUM_PU-1:0] io_ack;
	ctx_pkg::ctx_word_t io_ack_data [`NUM_PU];
	logic tbl_wr;
	logic [`TBL_IDX_W-1:0] tbl_waddr;
	ctx_pkg::slot_t tbl_wdata;
	logic cfg_rd;
	logic cfg_wr;
	logic [`MEM_AW-1:0] cfg_addr;
	ctx_pkg::ctx_word_t cfg_wdata;
	logic cfg_ack;
	ctx_pkg::ctx_word_t cfg_rdata;

	ctx_pkg::slot_t model_tbl [2**`TBL_IDX_W];
	ctx_pkg::ctx_word_t model_mem [2**`MEM_AW];
	int errors;
	int tests_passed;
	int tests_failed;
	int rr_ptr; // Next PU the arbiter favours.
	int cyc;
	int ack_pu [$];
	int ack_cyc [$];

	conn_context_top conn_context_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Ack monitor, grant order equals ack order.
	always @(negedge clk) begin
		cyc++;
		for (int i = 0; i < `NUM_PU; i++) begin
			if (io_ack[i] === 1'b1) begin
				ack_pu.push_back(i);
				ack_cyc.push_back(cyc);
			end
		end
	end

	task automatic check_word(input string name, input ctx_pkg::ctx_word_t exp,
		input ctx_pkg::ctx_word_t act);
		assert (act === exp)
		else begin
			$display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("%-24s passed", name);
		end else begin
			tests_failed++;
			$display("%-24s failed", name);
		end
	endtask

	task automatic table_write(input int idx, input ctx_pkg::slot_t slot);
		@(negedge clk);
		tbl_wr = 1'b1;
		tbl_waddr = `TBL_IDX_W'(idx);
		tbl_wdata = slot;
		model_tbl[idx] = slot;
		@(negedge clk);
		tbl_wr = 1'b0;
	endtask

	task automatic cfg_access(input logic wr, input int addr, input ctx_pkg::ctx_word_t wdata,
		output ctx_pkg::ctx_word_t rdata);
		int cnt;
		@(negedge clk);
		cfg_addr = `MEM_AW'(addr);
		cfg_wdata = wdata;
		cfg_wr = wr;
		cfg_rd = !wr;
		@(negedge clk);
		cnt = 1;
		while (cfg_ack !== 1'b1 && cnt < CFG_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (cfg_ack !== 1'b1) begin
			$display("ERROR: configuration access to %0d never completed", addr);
			errors++;
		end
		rdata = cfg_rdata;
		cfg_wr = 1'b0;
		cfg_rd = 1'b0;
	endtask

	task automatic cfg_check(input int addr);
		ctx_pkg::ctx_word_t rd;
		cfg_access(1'b0, addr, '0, rd);
		check_word("cfg_rdata", model_mem[addr], rd);
	endtask

	task automatic lookup(input int pu, input int idx, input int off, output int latency);
		ctx_pkg::ctx_word_t exp;
		int cnt;
		exp = model_mem[{model_tbl[idx], `OFFSET_W'(off)}];
		@(negedge clk);
		io_addr[pu].ctx.region = `REGION_W'(`CTX_REGION);
		io_addr[pu].ctx.tbl_idx = `TBL_IDX_W'(idx);
		io_addr[pu].ctx.offset = `OFFSET_W'(off);
		io_req[pu] = 1'b1;
		@(negedge clk);
		io_req[pu] = 1'b0;
		cnt = 1;
		while (io_ack[pu] !== 1'b1 && cnt < ACK_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		latency = cnt;
		if (io_ack[pu] !== 1'b1) begin
			$display("ERROR: PU %0d got no ack within %0d cycles", pu, ACK_TIMEOUT);
			errors++;
		end else begin
			check_word($sformatf("io_ack_data[%0d]", pu), exp, io_ack_data[pu]);
			rr_ptr = (pu + 1) % `NUM_PU; // One past the granted PU.
		end
	endtask

	task automatic stray_request(input int pu);
		int cnt;
		@(negedge clk);
		io_addr[pu].rgn.region = `REGION_W'(`CTX_REGION + 1); // Outside the context region.
		io_addr[pu].rgn.rest = '1;
		io_req[pu] = 1'b1;
		@(negedge clk);
		io_req[pu] = 1'b0;
		cnt = 1;
		while (io_ack[pu] !== 1'b1 && cnt < ACK_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		assert (io_ack[pu] !== 1'b1)
		else begin
			$display("ERROR: request outside the context region from PU %0d was answered", pu);
			errors++;
		end
	endtask

	task automatic pu_stream(input int pu, input int count);
		int gap;
		int lat;
		for (int n = 0; n < count; n++) begin
			lookup(pu, $urandom % 256, $urandom % 64, lat);
			gap = $urandom % 3;
			for (int g = 0; g < gap; g++)
				@(negedge clk);
		end
	endtask

	initial begin
		int start;
		int first;
		int idx;
		int off;
		int lat;
		ctx_pkg::ctx_word_t rd;
		void'($urandom(17));
		rst_n = 1'b0;
		io_req = '0;
		for (int i = 0; i < `NUM_PU; i++)
			io_addr[i] = '0;
		tbl_wr = 1'b0;
		tbl_waddr = '0;
		tbl_wdata = '0;
		cfg_rd = 1'b0;
		cfg_wr = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < 2**`TBL_IDX_W; i++)
			table_write(i, ctx_pkg::slot_t'($urandom % 16));

		start = errors;
		for (int a = 0; a < 2**`MEM_AW; a++) begin
			model_mem[a] = $urandom;
			cfg_access(1'b1, a, model_mem[a], rd);
		end
		for (int n = 0; n < 32; n++)
			cfg_check($urandom % 1024);
		finish_test("cfg write and readback", start);

		start = errors;
		idx = $urandom % 256;
		off = $urandom % 64;
		lookup(1, idx, off, lat);
		check_word("io_ack latency", 4, lat);
		finish_test("single lookup", start);

		start = errors;
		table_write(idx, ctx_pkg::slot_t'(model_tbl[idx] + 1 + $urandom % 15)); // New slot.
		repeat (2) @(negedge clk);
		lookup(1, idx, off, lat);
		finish_test("remap", start);

		start = errors;
		first = rr_ptr;
		@(negedge clk); // Remap ack is logged by now.
		ack_pu.delete();
		ack_cyc.delete();
		for (int p = 0; p < `NUM_PU; p++) begin
			automatic int q = p;
			automatic int ix = $urandom % 256;
			automatic int of = $urandom % 64;
			fork
				lookup(q, ix, of, lat);
			join_none
		end
		wait fork;
		@(negedge clk); // Last ack reaches the monitor.
		if (ack_pu.size() != `NUM_PU) begin
			$display("ERROR: expected %0d acks under contention, saw %0d", `NUM_PU, ack_pu.size());
			errors++;
		end
		for (int k = 0; k < ack_pu.size(); k++) begin
			check_word("io_ack order", (first + k) % `NUM_PU, ack_pu[k]);
			if (k > 0)
				check_word("io_ack spacing", 1, ack_cyc[k] - ack_cyc[k-1]);
		end
		finish_test("contention", start);

		start = errors;
		fork
			stray_request(0);
			lookup(`NUM_PU - 1, $urandom % 256, $urandom % 64, lat);
		join
		finish_test("region filter", start);

		start = errors;
		fork
			for (int n = 0; n < 20; n++)
				cfg_check($urandom % 1024);
			begin
				for (int p = 0; p < `NUM_PU; p++) begin
					automatic int q = p;
					fork
						pu_stream(q, 12);
					join_none
				end
				wait fork;
			end
		join
		finish_test("cfg under load", start);

		$display("tests passed %0d, failed %0d, assertion errors %0d", tests_passed,
			tests_failed, conn_context_top_i.sva_i.error_count);
		if (tests_failed == 0 && conn_context_top_i.sva_i.error_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* conn_context_top.sv */
// Connection context lookup top
`include "ctx_defs.svh"

module conn_context_top (
	input logic clk,
	input logic rst_n,

	input logic [`NUM_PU-1:0] io_req,
	input ctx_pkg::pu_addr_u io_addr [`NUM_PU],
	output logic [`NUM_PU-1:0] io_ack,
	output ctx_pkg::ctx_word_t io_ack_data [`NUM_PU],

	input logic tbl_wr,
	input logic [`TBL_IDX_W-1:0] tbl_waddr,
	input ctx_pkg::slot_t tbl_wdata,

	input logic cfg_rd,
	input logic cfg_wr,
	input logic [`MEM_AW-1:0] cfg_addr,
	input ctx_pkg::ctx_word_t cfg_wdata,
	output logic cfg_ack,
	output ctx_pkg::ctx_word_t cfg_rdata
);

	logic [`NUM_PU-1:0] pending;
	logic grant;
	ctx_pkg::pu_id_t grant_id;

	ctx_lookup_if lk_arb ();
	ctx_lookup_if lk_tbl ();

	ctx_req_capture u_req_capture (
		.clk(clk),
		.rst_n(rst_n),
		.io_req(io_req),
		.io_addr(io_addr),
		.pending(pending),
		.grant(grant),
		.grant_id(grant_id),
		.lookup(lk_arb)
	);

	ctx_rr_arbiter u_rr_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.pending(pending),
		.grant(grant),
		.grant_id(grant_id)
	);

	ctx_index_table u_index_table (
		.clk(clk),
		.rst_n(rst_n),
		.tbl_wr(tbl_wr),
		.tbl_waddr(tbl_waddr),
		.tbl_wdata(tbl_wdata),
		.lookup_in(lk_arb),
		.lookup_out(lk_tbl)
	);

	ctx_data_mem u_data_mem (
		.clk(clk),
		.rst_n(rst_n),
		.lookup(lk_tbl),
		.cfg_rd(cfg_rd),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack),
		.cfg_rdata(cfg_rdata),
		.io_ack(io_ack),
		.io_ack_data(io_ack_data)
	);

endmodule

/* ctx_data_mem.sv */
// Context data memory
`include "ctx_defs.svh"

module ctx_data_mem (
	input logic clk,
	input logic rst_n,

	ctx_lookup_if.dst lookup,

	input logic cfg_rd,
	input logic cfg_wr,
	input logic [`MEM_AW-1:0] cfg_addr,
	input ctx_pkg::ctx_word_t cfg_wdata,
	output logic cfg_ack,
	output ctx_pkg::ctx_word_t cfg_rdata,

	output logic [`NUM_PU-1:0] io_ack,
	output ctx_pkg::ctx_word_t io_ack_data [`NUM_PU]
);

	ctx_pkg::ctx_word_t mem [2**`MEM_AW];

	logic [`MEM_AW-1:0] lk_addr;
	logic [`NUM_PU-1:0] ack_sel;
	logic cfg_go;

	assign lk_addr = {lookup.slot, lookup.offset};

	// Host access only in a cycle the lookup leaves free.
	// The ack cycle blocks a second access while the level is still up.
	assign cfg_go = (cfg_rd || cfg_wr) && !cfg_ack && !lookup.valid;

	always_comb begin
		for (int i = 0; i < `NUM_PU; i++) begin
			ack_sel[i] = lookup.valid && (lookup.pu_id == i);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			io_ack <= '0;
			for (int i = 0; i < `NUM_PU; i++) begin
				io_ack_data[i] <= '0;
			end
		end else begin
			io_ack <= ack_sel;
			for (int i = 0; i < `NUM_PU; i++) begin
				io_ack_data[i] <= ack_sel[i] ? mem[lk_addr] : '0; // Idle PUs see zero.
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cfg_ack <= 1'b0;
		else
			cfg_ack <= cfg_go;
	end

	always_ff @(posedge clk) begin
		if (cfg_go)
			cfg_rdata <= mem[cfg_addr];
	end

	always_ff @(posedge clk) begin
		if (cfg_go && cfg_wr)
			mem[cfg_addr] <= cfg_wdata;
	end

endmodule

/* ctx_defs.svh */
// Connection context lookup parameters
`ifndef CTX_DEFS_SVH
`define CTX_DEFS_SVH

// Processing units sharing the lookup, 2 to 8.
`define NUM_PU 4
`define PU_ID_W 2

// PU request address and its fields.
`define ADDR_W 16
`define REGION_W 2
`define CTX_REGION 1
`define TBL_IDX_W 8
`define OFFSET_W 6

// Context data memory.
`define SLOT_W 4
`define MEM_AW (`SLOT_W + `OFFSET_W)
`define DATA_W 32

`endif

/* ctx_index_table.sv */
// Table index to context slot remap
`include "ctx_defs.svh"

module ctx_index_table (
	input logic clk,
	input logic rst_n,

	input logic tbl_wr,
	input logic [`TBL_IDX_W-1:0] tbl_waddr,
	input ctx_pkg::slot_t tbl_wdata,

	ctx_lookup_if.dst lookup_in,
	ctx_lookup_if.src lookup_out
);

	ctx_pkg::slot_t tbl [2**`TBL_IDX_W];

	logic wr_q;
	logic [`TBL_IDX_W-1:0] waddr_q;
	ctx_pkg::slot_t wdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_q <= 1'b0;
			lookup_out.valid <= 1'b0;
		end else begin
			wr_q <= tbl_wr;
			lookup_out.valid <= lookup_in.valid;
		end
	end

	always_ff @(posedge clk) begin
		waddr_q <= tbl_waddr;
		wdata_q <= tbl_wdata;
		if (wr_q)
			tbl[waddr_q] <= wdata_q; // A read on this edge still sees the old slot.
	end

	always_ff @(posedge clk) begin
		if (lookup_in.valid) begin
			lookup_out.slot <= tbl[lookup_in.tbl_idx];
			lookup_out.pu_id <= lookup_in.pu_id;
			lookup_out.tbl_idx <= lookup_in.tbl_idx;
			lookup_out.offset <= lookup_in.offset;
		end
	end

endmodule

/* ctx_lookup_if.sv */
// Lookup between pipeline stages
`include "ctx_defs.svh"

interface ctx_lookup_if;

	logic valid; // One-cycle strobe, no back-pressure.
	ctx_pkg::pu_id_t pu_id;
	logic [`TBL_IDX_W-1:0] tbl_idx;
	logic [`OFFSET_W-1:0] offset;
	ctx_pkg::slot_t slot;

	modport src (
		output valid,
		output pu_id,
		output tbl_idx,
		output offset,
		output slot
	);

	modport dst (
		input valid,
		input pu_id,
		input tbl_idx,
		input offset,
		input slot
	);

endinterface

/* ctx_pkg.sv */
// Connection context types
`include "ctx_defs.svh"

package ctx_pkg;

	typedef logic [`PU_ID_W-1:0] pu_id_t;
	typedef logic [`SLOT_W-1:0] slot_t;
	typedef logic [`DATA_W-1:0] ctx_word_t;

	// Region view, used to filter requests.
	typedef struct packed {
		logic [`REGION_W-1:0] region;
		logic [`ADDR_W-`REGION_W-1:0] rest;
	} region_view_t;

	// Context view, region followed by table index and word offset.
	typedef struct packed {
		logic [`REGION_W-1:0] region;
		logic [`TBL_IDX_W-1:0] tbl_idx;
		logic [`OFFSET_W-1:0] offset;
	} ctx_view_t;

	typedef union packed {
		region_view_t rgn;
		ctx_view_t ctx;
	} pu_addr_u;

endpackage

/* ctx_req_capture.sv */
// PU request capture
`include "ctx_defs.svh"

module ctx_req_capture (
	input logic clk,
	input logic rst_n,

	input logic [`NUM_PU-1:0] io_req,
	input ctx_pkg::pu_addr_u io_addr [`NUM_PU],

	output logic [`NUM_PU-1:0] pending,
	input logic grant,
	input ctx_pkg::pu_id_t grant_id,

	ctx_lookup_if.src lookup
);

	logic [`NUM_PU-1:0] accept;
	ctx_pkg::pu_addr_u addr_q [`NUM_PU];

	always_comb begin
		for (int i = 0; i < `NUM_PU; i++) begin
			accept[i] = io_req[i] && (io_addr[i].rgn.region == `REGION_W'(`CTX_REGION));
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			for (int i = 0; i < `NUM_PU; i++) begin
				if (grant && (grant_id == i))
					pending[i] <= 1'b0;
				if (accept[i])
					pending[i] <= 1'b1; // PU waits for its ack, so no overlap with clear.
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `NUM_PU; i++) begin
			if (accept[i])
				addr_q[i] <= io_addr[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			lookup.valid <= 1'b0;
		else
			lookup.valid <= grant;
	end

	always_ff @(posedge clk) begin
		if (grant) begin
			lookup.pu_id <= grant_id;
			lookup.tbl_idx <= addr_q[grant_id].ctx.tbl_idx;
			lookup.offset <= addr_q[grant_id].ctx.offset;
		end
	end

endmodule

/* ctx_rr_arbiter.sv */
// Round-robin arbiter
`include "ctx_defs.svh"

module ctx_rr_arbiter (
	input logic clk,
	input logic rst_n,

	input logic [`NUM_PU-1:0] pending,

	output logic grant,
	output ctx_pkg::pu_id_t grant_id
);

	ctx_pkg::pu_id_t ptr;

	// First pending PU at or after the pointer.
	always_comb begin
		int idx;
		grant = 1'b0;
		grant_id = '0;
		for (int k = 0; k < `NUM_PU; k++) begin
			idx = (int'(ptr) + k) % `NUM_PU;
			if (!grant && pending[idx]) begin
				grant = 1'b1;
				grant_id = ctx_pkg::pu_id_t'(idx);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (grant) begin
			if (grant_id == ctx_pkg::pu_id_t'(`NUM_PU - 1))
				ptr <= '0;
			else
				ptr <= grant_id + 1'b1; // One past the winner.
		end
	end

endmodule
